//--- sim/fas_pip_tests.txt
// Columns: ctl opcode state map_empty exp_start exp_wren exp_sel, one clock cycle per line
// ctl b0 fas_rdy_n b1 krnl_count b2 dwc_fifo_rden; exp_sel b0 enable b1 pm b2 rm0 b3 rm1 b4 rm_conv b5 pv
// Required FIFO empty or wrong state issues nothing
0 00 10 4  0 0 00
4 06 10 1  0 0 00
0 03 20 8  0 0 00
0 0A 01 0  0 0 00
0 09 40 0  0 0 00
0 05 10 8  0 0 00
// Opcodes 0 and 1, then three held-off cycles with depthwise reads
0 00 10 0  0 0 00
2 00 10 8  2 0 00
0 01 20 4  2 0 00
4 01 10 0  2 0 03
4 00 10 0  0 0 21
0 02 10 0  0 0 13
// Opcodes 1 and 11
2 01 10 0  0 0 00
0 0B 10 0  2 0 00
2 0B 20 4  2 0 00
4 02 10 0  2 0 01
4 03 10 0  0 0 13
4 04 10 0  0 0 21
// Opcodes 4, 5 and 8 back to back, rm1 lines overlap
0 04 10 0  0 0 00
0 05 10 0  4 0 00
2 08 20 8  4 0 00
4 05 10 0  0 2 03
4 07 10 0  0 0 23
0 06 10 0  0 0 23
// Opcodes 4 and 5 later kernel, opcode 6
2 04 10 8  0 0 00
2 05 10 0  4 0 00
0 06 10 2  4 0 08
0 06 10 0  2 2 09
0 07 10 0  0 0 09
0 07 10 0  0 0 05
// Opcodes 6 and 7
2 06 10 0  0 0 00
0 07 20 2  2 2 00
2 07 10 0  2 0 00
4 00 10 0  2 0 01
4 09 10 0  0 0 15
0 02 10 0  0 0 01
// Opcodes 2, 12 and 14
2 02 10 E  0 0 00
0 0C 20 0  1 0 00
2 0E 10 6  1 0 00
0 03 10 0  1 0 01
0 0D 10 0  0 0 01
0 03 10 0  0 0 01
// Opcodes 3, 13 and 9
0 03 10 6  0 0 00
2 0D 10 0  1 0 00
0 09 20 A  1 0 00
0 11 10 0  0 1 01
0 11 10 0  0 0 01
0 11 10 0  0 0 05
// Opcodes 17, 10 and 15
2 11 10 2  0 0 00
0 0A 10 C  0 1 00
2 0F 20 0  2 0 00
0 0F 10 0  0 1 05
0 0F 10 0  0 0 03
0 0F 10 0  0 0 03
// fas_rdy_n raised with issues and a pv tag in flight
0 04 10 0  0 0 00
4 05 10 0  4 0 00
1 05 10 0  4 0 20
0 00 01 F  0 0 00
0 00 01 F  0 0 00
0 00 01 F  0 0 00
0 00 01 F  0 0 00
0 00 01 F  0 0 00
0 00 01 F  0 0 00
0 00 01 F  0 0 00

//--- filelist.f
+incdir+logic
logic/fas_pip_pkg.sv
logic/fas_strobe_delay.sv
logic/fas_issue_ctrl.sv
logic/fas_dwc_tag.sv
logic/fas_strobe_align.sv
logic/fas_pip_ctrl.sv
sim/fas_pip_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module fas_pip_ctrl_tb -f filelist.f &&
./obj_dir/Vfas_pip_ctrl_tb | tee /dev/stderr |
    grep -F "Simulation finished: PASS" > /dev/null &&
echo "run_sim.sh: run passed" ||
{ echo "run_sim.sh: run failed"; exit 1; }

//--- sim/fas_pip_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fas_pip_ctrl_tb
    import fas_pip_pkg::*;
();

    ////////////////////
    // Replay setup
    ////////////////////

    // Seven hex columns per vector line
    localparam int COLS        = 7;
    localparam int MAX_VECTORS = 128;
    localparam int MAX_CYCLES  = 400;
    localparam int IDLE_LIMIT  = 20;
    // Unloaded memory words keep this value
    localparam logic [19:0] END_MARK = 20'hFFFFF;

    logic       clk_FAS;
    logic       rst_n;
    logic       fas_rdy_n;
    opcode_t    opcode_cfg;
    fas_state_t state;
    map_empty_t map_empty;
    logic       krnl_count;
    logic       dwc_fifo_rden;

    // DUT outputs
    logic pipe_enable;
    logic conv1x1_pip_start0;
    logic conv1x1_pip_start1;
    logic conv1x1_pip_start2;
    logic vector_add_pm;
    logic vector_add_rm0;
    logic vector_add_rm1;
    logic vector_add_rm_conv;
    logic vector_add_pv;
    logic outbuf_fifo_wren1;
    logic outbuf_fifo_wren2;

    logic [19:0] vec_mem [0:COLS*MAX_VECTORS-1];

    int start_errors = 0;
    int wren_errors  = 0;
    int vec_errors   = 0;
    int other_errors = 0;

    fas_pip_ctrl DUT (
        .clk_FAS            (clk_FAS),
        .rst_n              (rst_n),
        .fas_rdy_n          (fas_rdy_n),
        .opcode_cfg         (opcode_cfg),
        .state              (state),
        .map_empty          (map_empty),
        .krnl_count         (krnl_count),
        .dwc_fifo_rden      (dwc_fifo_rden),
        .pipe_enable        (pipe_enable),
        .conv1x1_pip_start0 (conv1x1_pip_start0),
        .conv1x1_pip_start1 (conv1x1_pip_start1),
        .conv1x1_pip_start2 (conv1x1_pip_start2),
        .vector_add_pm      (vector_add_pm),
        .vector_add_rm0     (vector_add_rm0),
        .vector_add_rm1     (vector_add_rm1),
        .vector_add_rm_conv (vector_add_rm_conv),
        .vector_add_pv      (vector_add_pv),
        .outbuf_fifo_wren1  (outbuf_fifo_wren1),
        .outbuf_fifo_wren2  (outbuf_fifo_wren2)
    );

    // 100 ns period
    always #50 clk_FAS = ~clk_FAS;

    ////////////////////
    // Compare tasks
    ////////////////////

    // Bit n is start n
    task automatic check_starts(input int vec, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            start_errors++;
            $display("FAIL at %0t: vector %0d start pulses %b, expected %b",
                     $time, vec, got, exp);
        end
    endtask

    // Bit 0 wren1, bit 1 wren2
    task automatic check_wren(input int vec, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            wren_errors++;
            $display("FAIL at %0t: vector %0d outbuf write pulses %b, expected %b",
                     $time, vec, got, exp);
        end
    endtask

    // Enable, pm/rm0/rm1, then rm_conv and pv
    task automatic check_vec_sel(input int vec, input logic got_en, input vec_sel_t got_sel,
                                 input logic [1:0] got_dwc, input logic [5:0] exp);
        logic [5:0] got;
        got = {got_dwc, got_sel, got_en};
        if (got !== exp) begin
            vec_errors++;
            $display("FAIL at %0t: vector %0d enable and adder selects %b, expected %b",
                     $time, vec, got, exp);
        end
    endtask

    function automatic logic outputs_busy();
        return |{pipe_enable, conv1x1_pip_start0, conv1x1_pip_start1, conv1x1_pip_start2,
                 vector_add_pm, vector_add_rm0, vector_add_rm1, vector_add_rm_conv,
                 vector_add_pv, outbuf_fifo_wren1, outbuf_fifo_wren2};
    endfunction

    // Outputs settle to zero once reset is released
    task automatic wait_outputs_idle();
        int waited;
        waited = 0;
        @(negedge clk_FAS);
        while (outputs_busy() && waited < IDLE_LIMIT) begin
            @(negedge clk_FAS);
            waited++;
        end
        if (outputs_busy()) begin
            other_errors++;
            $display("Timed out after %0d cycles waiting for the outputs to go idle", IDLE_LIMIT);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int          num_vectors;
        int          base;
        logic [19:0] ctl;
        clk_FAS = 1'b0;
        rst_n         <= 1'b0;
        fas_rdy_n     <= 1'b0;
        opcode_cfg    <= '0;
        state         <= st_idle;
        map_empty     <= '1;
        krnl_count    <= 1'b0;
        dwc_fifo_rden <= 1'b0;
        for (int i = 0; i < COLS * MAX_VECTORS; i++) begin
            vec_mem[i] = END_MARK;
        end
        $readmemh("sim/fas_pip_tests.txt", vec_mem);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && vec_mem[num_vectors * COLS] != END_MARK) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            other_errors++;
            $display("No test vectors were read from sim/fas_pip_tests.txt");
        end
        // Reset for 10 cycles
        repeat (10) @(posedge clk_FAS);
        rst_n <= 1'b1;
        wait_outputs_idle();
        for (int i = 0; i < num_vectors; i++) begin
            base = i * COLS;
            ctl  = vec_mem[base];
            @(posedge clk_FAS);
            fas_rdy_n     <= ctl[0];
            krnl_count    <= ctl[1];
            dwc_fifo_rden <= ctl[2];
            opcode_cfg    <= opcode_t'(1) << vec_mem[base + 1];
            state         <= fas_state_t'(vec_mem[base + 2][6:0]);
            map_empty     <= map_empty_t'(vec_mem[base + 3][3:0]);
            // Mid-cycle, away from the edge
            @(negedge clk_FAS);
            check_starts(i, {conv1x1_pip_start2, conv1x1_pip_start1, conv1x1_pip_start0},
                         vec_mem[base + 4][2:0]);
            check_wren(i, {outbuf_fifo_wren2, outbuf_fifo_wren1}, vec_mem[base + 5][1:0]);
            check_vec_sel(i, pipe_enable, {vector_add_rm1, vector_add_rm0, vector_add_pm},
                          {vector_add_pv, vector_add_rm_conv}, vec_mem[base + 6][5:0]);
        end
        $display("Errors: starts %0d, wren %0d, vec_sel %0d, other %0d",
                 start_errors, wren_errors, vec_errors, other_errors);
        if (start_errors + wren_errors + vec_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Hang guard
    initial begin
        int cycles;
        for (cycles = 0; cycles < MAX_CYCLES; cycles++) begin
            @(posedge clk_FAS);
        end
        $display("Timeout: the vector replay did not end within %0d clock cycles", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/fas_pip_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fas_pip_ctrl
    import fas_pip_pkg::*;
(
    input  wire             clk_FAS,
    input  wire             rst_n,
    input  wire             fas_rdy_n,
    input  wire opcode_t    opcode_cfg,
    input  wire fas_state_t state,
    input  wire map_empty_t map_empty,
    input  wire             krnl_count,
    input  wire             dwc_fifo_rden,
    output logic            pipe_enable,
    output logic            conv1x1_pip_start0,
    output logic            conv1x1_pip_start1,
    output logic            conv1x1_pip_start2,
    output logic            vector_add_pm,
    output logic            vector_add_rm0,
    output logic            vector_add_rm1,
    output logic            vector_add_rm_conv,
    output logic            vector_add_pv,
    output logic            outbuf_fifo_wren1,
    output logic            outbuf_fifo_wren2
);

    // Issue stage to align stage
    logic     issue_enable;
    vec_sel_t issue_vec_sel;

    // Depthwise tags
    logic rm_conv_tag;
    logic pv_tag;

    ////////////////////
    // Issue path
    ////////////////////

    // pipe_enable fed back for the hold-off
    fas_issue_ctrl u_issue (
        .clk_FAS            (clk_FAS),
        .rst_n              (rst_n),
        .fas_rdy_n          (fas_rdy_n),
        .opcode_cfg         (opcode_cfg),
        .state              (state),
        .map_empty          (map_empty),
        .krnl_count         (krnl_count),
        .pipe_enable        (pipe_enable),
        .issue_enable       (issue_enable),
        .issue_vec_sel      (issue_vec_sel),
        .conv1x1_pip_start0 (conv1x1_pip_start0),
        .conv1x1_pip_start1 (conv1x1_pip_start1),
        .conv1x1_pip_start2 (conv1x1_pip_start2),
        .outbuf_fifo_wren1  (outbuf_fifo_wren1),
        .outbuf_fifo_wren2  (outbuf_fifo_wren2)
    );

    // Depthwise path, independent of issue
    fas_dwc_tag u_dwc_tag (
        .clk_FAS       (clk_FAS),
        .rst_n         (rst_n),
        .fas_rdy_n     (fas_rdy_n),
        .opcode_cfg    (opcode_cfg),
        .dwc_fifo_rden (dwc_fifo_rden),
        .rm_conv_tag   (rm_conv_tag),
        .pv_tag        (pv_tag)
    );

    ////////////////////
    // Alignment
    ////////////////////

    fas_strobe_align u_align (
        .clk_FAS            (clk_FAS),
        .rst_n              (rst_n),
        .fas_rdy_n          (fas_rdy_n),
        .issue_enable       (issue_enable),
        .issue_vec_sel      (issue_vec_sel),
        .rm_conv_tag        (rm_conv_tag),
        .pv_tag             (pv_tag),
        .pipe_enable        (pipe_enable),
        .vector_add_pm      (vector_add_pm),
        .vector_add_rm0     (vector_add_rm0),
        .vector_add_rm1     (vector_add_rm1),
        .vector_add_rm_conv (vector_add_rm_conv),
        .vector_add_pv      (vector_add_pv)
    );

endmodule

`default_nettype wire

//--- logic/fas_strobe_align.sv
`timescale 1ns/10ps
`default_nettype none

`include "fas_pip_defines.svh"

module fas_strobe_align
    import fas_pip_pkg::*;
(
    input  wire           clk_FAS,
    input  wire           rst_n,
    input  wire           fas_rdy_n,
    input  wire           issue_enable,
    input  wire vec_sel_t issue_vec_sel,
    input  wire           rm_conv_tag,
    input  wire           pv_tag,
    output logic          pipe_enable,
    output logic          vector_add_pm,
    output logic          vector_add_rm0,
    output logic          vector_add_rm1,
    output logic          vector_add_rm_conv,
    output logic          vector_add_pv
);

    ////////////////////
    // FIFO read alignment
    ////////////////////

    // Enable lands with the map FIFO data
    fas_strobe_delay #(.DEPTH(`FAS_FIFO_LATENCY)) u_enable_dly (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .clear   (fas_rdy_n),
        .din     (issue_enable),
        .dout    (pipe_enable)
    );

    fas_strobe_delay #(.DEPTH(`FAS_FIFO_LATENCY)) u_pm_dly (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .clear   (fas_rdy_n),
        .din     (issue_vec_sel[VSEL_PM]),
        .dout    (vector_add_pm)
    );

    fas_strobe_delay #(.DEPTH(`FAS_FIFO_LATENCY)) u_rm0_dly (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .clear   (fas_rdy_n),
        .din     (issue_vec_sel[VSEL_RM0]),
        .dout    (vector_add_rm0)
    );

    // Second residual add waits for the first adder pass
    fas_strobe_delay #(.DEPTH(`RM1_LATENCY)) u_rm1_dly (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .clear   (fas_rdy_n),
        .din     (issue_vec_sel[VSEL_RM1]),
        .dout    (vector_add_rm1)
    );

    ////////////////////
    // Depthwise selects
    ////////////////////

    // Already aligned to the depthwise read
    assign vector_add_rm_conv = rm_conv_tag;
    assign vector_add_pv      = pv_tag;

endmodule

`default_nettype wire

//--- logic/fas_dwc_tag.sv
`timescale 1ns/10ps
`default_nettype none

module fas_dwc_tag
    import fas_pip_pkg::*;
(
    input  wire          clk_FAS,
    input  wire          rst_n,
    input  wire          fas_rdy_n,
    input  wire opcode_t opcode_cfg,
    input  wire          dwc_fifo_rden,
    output logic         rm_conv_tag,
    output logic         pv_tag
);

    logic rm_conv_op;
    logic pv_op;

    ////////////////////
    // Opcode classes
    ////////////////////

    // Residual conv add
    assign rm_conv_op = opcode_cfg[0] || opcode_cfg[2];

    // Previous vector add
    assign pv_op = opcode_cfg[1] || opcode_cfg[3] || opcode_cfg[5] || opcode_cfg[7];

    // Tag each depthwise read one cycle later
    always_ff @(posedge clk_FAS) begin
        if (!rst_n || fas_rdy_n) begin
            rm_conv_tag <= 1'b0;
            pv_tag      <= 1'b0;
        end else begin
            rm_conv_tag <= dwc_fifo_rden && rm_conv_op;
            pv_tag      <= dwc_fifo_rden && pv_op;
        end
    end

    // Adder takes one depthwise operand per read
    a_tags_exclusive: assert property (@(posedge clk_FAS) disable iff (!rst_n)
        !(rm_conv_tag && pv_tag))
        else $error("rm_conv and pv tags high together");

endmodule

`default_nettype wire

//--- logic/fas_issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fas_issue_ctrl
    import fas_pip_pkg::*;
(
    input  wire        clk_FAS,
    input  wire        rst_n,
    input  wire        fas_rdy_n,
    input  wire opcode_t    opcode_cfg,
    input  wire fas_state_t state,
    input  wire map_empty_t map_empty,
    input  wire        krnl_count,
    input  wire        pipe_enable,
    output logic       issue_enable,
    output vec_sel_t   issue_vec_sel,
    output logic       conv1x1_pip_start0,
    output logic       conv1x1_pip_start1,
    output logic       conv1x1_pip_start2,
    output logic       outbuf_fifo_wren1,
    output logic       outbuf_fifo_wren2
);

    // FIFO ready flags
    logic c_rdy;
    logic p_rdy;
    logic r_rdy;
    logic v_rdy;

    logic first_krnl;
    logic can_issue;

    // Next slice of strobes
    logic       nxt_enable;
    vec_sel_t   nxt_sel;
    logic [2:0] nxt_start;
    logic [2:1] nxt_wren;

    assign c_rdy = !map_empty[MAP_CONV];
    assign p_rdy = !map_empty[MAP_PART];
    assign r_rdy = !map_empty[MAP_RESD];
    assign v_rdy = !map_empty[MAP_PREV];

    assign first_krnl = (krnl_count == 1'b0);

    // Only while streaming and no delayed enable is in flight
    assign can_issue = (state == st_active || state == st_wait_last_write) && !pipe_enable;

    ////////////////////
    // Opcode decode
    ////////////////////

    // First matching row wins
    always_comb begin
        nxt_enable = 1'b0;
        nxt_sel    = '0;
        nxt_start  = '0;
        nxt_wren   = '0;
        if (can_issue) begin
            if (opcode_cfg[0] && c_rdy && p_rdy && r_rdy) begin
                nxt_enable       = 1'b1;
                nxt_sel[VSEL_PM] = first_krnl;
                nxt_start[1]     = 1'b1;
            end else if ((opcode_cfg[1] || opcode_cfg[11]) && c_rdy && p_rdy && v_rdy) begin
                nxt_enable       = 1'b1;
                nxt_sel[VSEL_PM] = first_krnl;
                nxt_start[1]     = 1'b1;
            end else if ((opcode_cfg[2] || opcode_cfg[12] || opcode_cfg[14]) && c_rdy) begin
                nxt_enable   = 1'b1;
                nxt_start[0] = 1'b1;
            end else if ((opcode_cfg[3] || opcode_cfg[13]) && c_rdy && v_rdy) begin
                nxt_enable   = 1'b1;
                nxt_start[0] = 1'b1;
            end else if (opcode_cfg[4] && c_rdy && p_rdy && r_rdy) begin
                nxt_enable        = 1'b1;
                nxt_sel[VSEL_PM]  = first_krnl;
                nxt_sel[VSEL_RM1] = first_krnl;
                nxt_start[2]      = 1'b1;
            end else if (opcode_cfg[5] && c_rdy && p_rdy && r_rdy && v_rdy) begin
                nxt_enable        = 1'b1;
                nxt_sel[VSEL_PM]  = first_krnl;
                nxt_sel[VSEL_RM1] = first_krnl;
                nxt_start[2]      = 1'b1;
            end else if (opcode_cfg[6] && c_rdy && r_rdy) begin
                nxt_enable        = 1'b1;
                nxt_sel[VSEL_RM0] = first_krnl;
                nxt_start[1]      = 1'b1;
                nxt_wren[2]       = 1'b1;
            end else if (opcode_cfg[7] && c_rdy && r_rdy && v_rdy) begin
                nxt_enable        = 1'b1;
                nxt_sel[VSEL_RM0] = first_krnl;
                nxt_start[1]      = 1'b1;
            end else if (opcode_cfg[8] && c_rdy && p_rdy && r_rdy) begin
                // Accumulating rows ignore the kernel count
                nxt_enable        = 1'b1;
                nxt_sel[VSEL_PM]  = 1'b1;
                nxt_sel[VSEL_RM1] = 1'b1;
                nxt_wren[2]       = 1'b1;
            end else if ((opcode_cfg[9] || opcode_cfg[17]) && c_rdy && r_rdy) begin
                nxt_enable        = 1'b1;
                nxt_sel[VSEL_RM0] = 1'b1;
                nxt_wren[1]       = 1'b1;
            end else if (opcode_cfg[10] && c_rdy && p_rdy) begin
                nxt_enable       = 1'b1;
                nxt_sel[VSEL_PM] = 1'b1;
                nxt_start[1]     = 1'b1;
            end else if (opcode_cfg[15] && c_rdy && p_rdy) begin
                nxt_enable       = 1'b1;
                nxt_sel[VSEL_PM] = 1'b1;
                nxt_wren[1]      = 1'b1;
            end
        end
    end

    ////////////////////
    // Strobe registers
    ////////////////////

    always_ff @(posedge clk_FAS) begin
        if (!rst_n || fas_rdy_n) begin
            issue_enable       <= 1'b0;
            issue_vec_sel      <= '0;
            conv1x1_pip_start0 <= 1'b0;
            conv1x1_pip_start1 <= 1'b0;
            conv1x1_pip_start2 <= 1'b0;
            outbuf_fifo_wren1  <= 1'b0;
            outbuf_fifo_wren2  <= 1'b0;
        end else begin
            issue_enable       <= nxt_enable;
            issue_vec_sel      <= nxt_sel;
            conv1x1_pip_start0 <= nxt_start[0];
            conv1x1_pip_start1 <= nxt_start[1];
            conv1x1_pip_start2 <= nxt_start[2];
            outbuf_fifo_wren1  <= nxt_wren[1];
            outbuf_fifo_wren2  <= nxt_wren[2];
        end
    end

    // Config must select a single opcode
    a_opcode_onehot0: assert property (@(posedge clk_FAS) disable iff (!rst_n)
        $onehot0(opcode_cfg))
        else $error("opcode_cfg has more than one bit set");

    // One pipeline variant per slice
    a_start_onehot0: assert property (@(posedge clk_FAS) disable iff (!rst_n)
        $onehot0({conv1x1_pip_start2, conv1x1_pip_start1, conv1x1_pip_start0}))
        else $error("more than one pipeline start pulse");

endmodule

`default_nettype wire

//--- logic/fas_strobe_delay.sv
`timescale 1ns/10ps
`default_nettype none

module fas_strobe_delay #(
    parameter int DEPTH = 2
) (
    input  wire  clk_FAS,
    input  wire  rst_n,
    input  wire  clear,
    input  wire  din,
    output logic dout
);

    // Stage 0 takes din
    logic [DEPTH-1:0] shift_q;

    ////////////////////
    // Shift line
    ////////////////////

    always_ff @(posedge clk_FAS) begin
        if (!rst_n || clear) begin
            shift_q <= '0;
        end else begin
            shift_q[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                shift_q[i] <= shift_q[i-1];
            end
        end
    end

    // Oldest stage
    assign dout = shift_q[DEPTH-1];

    // Zero depth has no meaning here
    if (DEPTH < 1) begin : g_bad_depth
        $error("fas_strobe_delay needs DEPTH of at least 1");
    end

endmodule

`default_nettype wire

//--- logic/fas_pip_pkg.sv
`default_nettype none

`include "fas_pip_defines.svh"

package fas_pip_pkg;

    ////////////////////
    // Configuration
    ////////////////////

    // One-hot opcode, bit n selects opcode n
    typedef logic [`OPCODE_WIDTH-1:0] opcode_t;

    // Main FSM states, one-hot
    typedef enum logic [`FSM_STATE_WIDTH-1:0] {
        st_idle            = 7'b0000001,
        st_ld_1x1_krn      = 7'b0000010,
        st_cfg_awp         = 7'b0000100,
        st_start_awp       = 7'b0001000,
        st_active          = 7'b0010000,
        st_wait_last_write = 7'b0100000,
        st_send_complete   = 7'b1000000
    } fas_state_t;

    ////////////////////
    // Status and selects
    ////////////////////

    // FIFO empty flags
    typedef logic [3:0] map_empty_t;
    localparam int MAP_CONV = 0;
    localparam int MAP_PART = 1;
    localparam int MAP_RESD = 2;
    localparam int MAP_PREV = 3;

    // Undelayed adder selects from the issue stage
    typedef logic [2:0] vec_sel_t;
    localparam int VSEL_PM  = 0;
    localparam int VSEL_RM0 = 1;
    localparam int VSEL_RM1 = 2;

endpackage

`default_nettype wire

//--- logic/fas_pip_defines.svh
`ifndef FAS_PIP_DEFINES_SVH
`define FAS_PIP_DEFINES_SVH

////////////////////
// Pipeline latencies
////////////////////

// Read latency of the map FIFOs, in cycles
`define FAS_FIFO_LATENCY 2

// Vector adder latency, in cycles
`define VEC_ADD_LATENCY 3

// Second residual select trails the FIFO read and the adder
`define RM1_LATENCY (2 * `FAS_FIFO_LATENCY + `VEC_ADD_LATENCY)

////////////////////
// Field widths
////////////////////

// One-hot opcode, bits 0 to 17
`define OPCODE_WIDTH 18
`define FSM_STATE_WIDTH 7

`endif
